//--- sim.f
chipRamPkg.sv
agnusPkg.sv
agnusSync.sv
dramAddrLatch.sv
refreshTimer.sv
sdramSequencer.sv
chipRamRegs.sv
chipRamTop.sv
chipRamTb.sv

//--- chipRamTb.sv
// Chip RAM controller testbench
// Random Agnus read and write slots under both revisions, refresh timing,
// power-up sequence and APB registers, checked against a local model

`timescale 1ns/1ps

module chipRamTb;

    localparam int slotCount    = 40;
    localparam int timeoutLimit = slotCount * 60 + 2000 + 500;

    logic                  C3;
    logic                  RESETn;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    agnusPkg::agnusInT     agnus;
    agnusPkg::draT         dra;
    chipRamPkg::sdramPinsT sdram;
    logic                  cpuCycle;
    logic                  dmaCycle;
    logic                  writeCycle;
    logic                  dbEnN;
    logic                  dbDir;
    logic                  ready;

    int  cycleCnt    = 0;
    int  checks      = 0;
    int  errors      = 0;
    int  refreshSeen = 0;
    // Refresh total at the last count clear
    int  refBase     = 0;
    bit  clkEnDropped;

    chipRamPkg::sdramCmdT  cmdQ[$];
    chipRamPkg::sdramAddrT addrQ[$];
    chipRamPkg::sdramCmdT  monCmd;

    chipRamTop #(
        .refreshInit (9'd290)
    ) i_chipRamTop (
        .C3         (C3),
        .RESETn     (RESETn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .agnus      (agnus),
        .dra        (dra),
        .sdram      (sdram),
        .cpuCycle   (cpuCycle),
        .dmaCycle   (dmaCycle),
        .writeCycle (writeCycle),
        .dbEnN      (dbEnN),
        .dbDir      (dbDir),
        .ready      (ready)
    );

    //////////////////////////////////////////////////
    // Clock, cycle count, timeout
    //////////////////////////////////////////////////

    initial begin
        C3 = 1'b0;
        forever #4 C3 = ~C3;
    end

    always @(posedge C3) begin
        cycleCnt <= cycleCnt + 1;
    end

    initial begin
        wait (cycleCnt >= timeoutLimit);
        $display("Timeout, the run did not finish within %0d cycles", timeoutLimit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // SDRAM command monitor sampling at the falling edge
    always @(negedge C3) begin
        if (RESETn) begin
            monCmd = chipRamPkg::sdramCmdT'({sdram.csN, sdram.rasN, sdram.casN, sdram.weN});
            if (monCmd != chipRamPkg::nop) begin
                cmdQ.push_back(monCmd);
                addrQ.push_back(sdram.addr);
            end
            if (monCmd == chipRamPkg::refresh) begin
                refreshSeen++;
            end
            if (monCmd == chipRamPkg::activate && !ready) begin
                reportFailure("activate issued before the SDRAM was ready");
            end
            if (!sdram.clkEn) begin
                clkEnDropped = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Helpers and model
    //////////////////////////////////////////////////

    // Drive point 1 ns after the rising edge
    task tick;
        @(posedge C3);
        #1;
    endtask

    task check(input string name, input logic [31:0] actual, input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task reportFailure(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task reportTest(input string name, input int errStart);
        $display("%s test done, %0d errors", name, errors - errStart);
    endtask

    // 8375 takes the whole row and 8372A puts RAS0n on top
    function automatic agnusPkg::rowAddrT expectRow(agnusPkg::agnusRevT rev, logic ras0Level,
                                                    agnusPkg::draT d);
        if (rev == agnusPkg::rev8375) begin
            return d;
        end
        return {ras0Level, d[9:1]};
    endfunction

    function automatic agnusPkg::colAddrT expectCol(agnusPkg::agnusRevT rev, agnusPkg::draT d);
        if (rev == agnusPkg::rev8375) begin
            return d[9:1];
        end
        return {1'b0, d[9:2]};
    endfunction

    // Word address line A1
    function automatic logic a1Of(agnusPkg::agnusRevT rev, agnusPkg::draT d);
        return (rev == agnusPkg::rev8375) ? d[0] : d[1];
    endfunction

    // Zero wait state APB transfer
    task automatic apbAccess(input bit doWrite, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        tick();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = doWrite;
        paddr   = addr;
        pwdata  = wdata;
        tick();
        penable = 1'b1;
        @(negedge C3);
        rdata = prdata;
        err   = pslverr;
        check("pready", pready, 1);
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Next command from the monitor with optional refresh skip
    task automatic popCmd(input bit skipRefresh, output chipRamPkg::sdramCmdT cmd,
                          output chipRamPkg::sdramAddrT addr);
        int n;
        bit found;
        found = 1'b0;
        n     = 0;
        cmd   = chipRamPkg::nop;
        addr  = '0;
        while (!found && n < 60) begin
            if (cmdQ.size() == 0) begin
                tick();
                n++;
            end else begin
                cmd   = cmdQ.pop_front();
                addr  = addrQ.pop_front();
                found = !(skipRefresh && cmd == chipRamPkg::refresh);
            end
        end
        if (!found) begin
            cmd = chipRamPkg::nop;
            reportFailure("no SDRAM command within 60 cycles");
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic powerUpTest;
        int start;
        int n;
        int errStart;
        chipRamPkg::sdramCmdT  cmd;
        chipRamPkg::sdramAddrT addr;
        errStart = errors;
        repeat (5) tick();
        // Idle outputs while reset is held
        check("ready", ready, 0);
        check("cpuCycle", cpuCycle, 0);
        check("dmaCycle", dmaCycle, 0);
        check("writeCycle", writeCycle, 0);
        check("sdram cmd", {sdram.csN, sdram.rasN, sdram.casN, sdram.weN}, 4'hf);
        check("clkEn", sdram.clkEn, 1);
        check("dbEnN", dbEnN, 1);
        check("dbDir", dbDir, 1);
        RESETn = 1'b1;
        start  = cycleCnt;
        n      = 0;
        while (!ready && n < 40) begin
            tick();
            n++;
            // Slot strobe during the sequence must not start an access
            if (n == 2) begin
                agnus.ras1N = 1'b0;
            end
            if (n == 8) begin
                agnus.ras1N = 1'b1;
            end
        end
        check("ready delay", cycleCnt - start, 14);
        popCmd(1'b0, cmd, addr);
        check("init cmd 1", cmd, chipRamPkg::precharge);
        check("precharge addr bit 10", addr[10], 1);
        popCmd(1'b0, cmd, addr);
        check("init cmd 2", cmd, chipRamPkg::modeReg);
        check("mode word", addr, chipRamPkg::modeWord);
        popCmd(1'b0, cmd, addr);
        check("init cmd 3", cmd, chipRamPkg::refresh);
        popCmd(1'b0, cmd, addr);
        check("init cmd 4", cmd, chipRamPkg::refresh);
        reportTest("power-up", errStart);
    endtask

    task automatic refreshTest;
        int interval;
        int i;
        int n;
        int start;
        int quiet;
        int errStart;
        logic [31:0] rdata;
        logic        err;
        errStart = errors;
        interval = 20 + $urandom % 41;
        apbAccess(1'b1, agnusPkg::regRefresh, interval, rdata, err);
        apbAccess(1'b1, agnusPkg::regStatus, 0, rdata, err);
        refBase = refreshSeen;
        // Bus idle with both phases low
        agnus.busPhase = 2'b00;
        for (i = 0; i < 5; i++) begin
            start = refreshSeen;
            n     = 0;
            while (refreshSeen == start && n < interval + 4) begin
                tick();
                n++;
            end
            if (refreshSeen == start) begin
                reportFailure($sformatf("no refresh within %0d cycles on an idle bus",
                                        interval + 4));
            end
        end
        agnus.busPhase = 2'b01;
        // Let any refresh in flight reach the pins
        repeat (4) tick();
        apbAccess(1'b0, agnusPkg::regStatus, 0, rdata, err);
        check("refresh count", rdata[15:8], (refreshSeen - refBase) & 8'hff);
        check("status ready", rdata[0], 1);
        quiet = refreshSeen;
        repeat (interval + 8) tick();
        agnus.busPhase = 2'b10;
        repeat (interval + 8) tick();
        check("refreshes with a phase high", refreshSeen, quiet);
        agnus.busPhase = 2'b11;
        reportTest("refresh", errStart);
    endtask

    task automatic apbRegTest;
        int i;
        int errStart;
        logic [31:0] v;
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  badAddr;
        errStart = errors;
        for (i = 0; i < 4; i++) begin
            v = $urandom;
            apbAccess(1'b1, agnusPkg::regCtrl, v, rdata, err);
            apbAccess(1'b0, agnusPkg::regCtrl, 0, rdata, err);
            check("regCtrl", rdata, v & 32'h1);
            check("pslverr", err, 0);
            v = $urandom;
            apbAccess(1'b1, agnusPkg::regRefresh, v, rdata, err);
            apbAccess(1'b0, agnusPkg::regRefresh, 0, rdata, err);
            check("regRefresh", rdata, v & 32'h1ff);
            check("pslverr", err, 0);
        end
        // Unmapped word address above the map
        badAddr = 8'h0c + 8'(4 * ($urandom % 60));
        apbAccess(1'b0, badAddr, 0, rdata, err);
        check("pslverr unmapped read", err, 1);
        apbAccess(1'b1, badAddr, $urandom, rdata, err);
        check("pslverr unmapped write", err, 1);
        apbAccess(1'b0, agnusPkg::regStatus, 0, rdata, err);
        check("refresh count", rdata[15:8], (refreshSeen - refBase) & 8'hff);
        apbAccess(1'b1, agnusPkg::regStatus, 0, rdata, err);
        refBase = refreshSeen;
        apbAccess(1'b0, agnusPkg::regStatus, 0, rdata, err);
        check("cleared count", rdata[15:8], 0);
        apbAccess(1'b1, agnusPkg::regRefresh, 290, rdata, err);
        apbAccess(1'b1, agnusPkg::regCtrl, agnusPkg::rev8375, rdata, err);
        reportTest("APB register", errStart);
    endtask

    task automatic slotTest(input bit doWrite, input string name);
        int i;
        int n;
        int errStart;
        bit dma;
        bit useRas0;
        agnusPkg::agnusRevT    rev;
        agnusPkg::draT         rowDra;
        agnusPkg::draT         colDra;
        chipRamPkg::sdramCmdT  cmd;
        chipRamPkg::sdramAddrT addr;
        logic [31:0]           rdata;
        logic                  err;
        errStart = errors;
        for (i = 0; i < slotCount / 2; i++) begin
            rev     = agnusPkg::agnusRevT'($urandom % 2);
            dma     = $urandom % 2;
            useRas0 = $urandom % 2;
            rowDra  = $urandom;
            colDra  = $urandom;
            apbAccess(1'b1, agnusPkg::regCtrl, rev, rdata, err);
            clkEnDropped = 1'b0;
            tick();
            dra        = rowDra;
            agnus.dbrN = !dma;
            agnus.aweN = !doWrite;
            tick();
            if (useRas0) begin
                agnus.ras0N = 1'b0;
            end else begin
                agnus.ras1N = 1'b0;
            end
            // Row held past the synchronizer before the column
            repeat (4) tick();
            dra = colDra;
            tick();
            agnus.busPhase = 2'b10;
            popCmd(1'b1, cmd, addr);
            check("activate cmd", cmd, chipRamPkg::activate);
            check("activate addr", addr, {1'b0, expectRow(rev, !useRas0, rowDra)});
            popCmd(1'b1, cmd, addr);
            check("access cmd", cmd, doWrite ? chipRamPkg::write : chipRamPkg::read);
            check("access addr", addr, {2'b10, expectCol(rev, colDra)});
            check("cpuCycle", cpuCycle, !dma);
            check("dmaCycle", dmaCycle, dma);
            check("writeCycle", writeCycle, doWrite);
            check("dbEnN", dbEnN, !(dma && a1Of(rev, colDra)));
            check("dbDir", dbDir, !doWrite);
            repeat (3) tick();
            // Bus state 7 ends the slot
            agnus.busPhase = 2'b00;
            n = 0;
            while ((cpuCycle || dmaCycle) && n < 20) begin
                tick();
                n++;
            end
            if (cpuCycle || dmaCycle) begin
                reportFailure("slot flags did not fall after both bus phases went low");
            end
            check("clkEn dropped", clkEnDropped, !doWrite);
            // All strobes idle and both phases high
            agnus = '1;
        end
        reportTest(name, errStart);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h2e59_6ca7));
        RESETn    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        agnus     = '1;
        dra       = '0;
        powerUpTest();
        refreshTest();
        apbRegTest();
        slotTest(1'b0, "read slot");
        slotTest(1'b1, "write slot");
        repeat (4) tick();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- chipRamTop.sv
// Chip RAM controller top level
// Turns Agnus multiplexed DRAM slots into single word SDRAM accesses,
// with programmable refresh and an APB register block

`timescale 1ns/1ps

module chipRamTop #(
    parameter chipRamPkg::refreshIntervalT refreshInit = 9'd290
) (
    input  logic                  C3,
    input  logic                  RESETn,
    // APB
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Agnus
    input  agnusPkg::agnusInT     agnus,
    input  agnusPkg::draT         dra,
    // SDRAM
    output chipRamPkg::sdramPinsT sdram,
    // Slot flags and bridge
    output logic                  cpuCycle,
    output logic                  dmaCycle,
    output logic                  writeCycle,
    output logic                  dbEnN,
    output logic                  dbDir,
    output logic                  ready
);

    agnusPkg::agnusSyncT         sync;
    agnusPkg::rowAddrT           rowAddr;
    agnusPkg::colAddrT           colAddr;
    agnusPkg::agnusRevT          rev;
    chipRamPkg::refreshIntervalT interval;
    logic                        colValid;
    logic                        colClear;
    logic                        refreshReq;
    logic                        refreshAck;

    agnusSync iAgnusSync (
        .C3     (C3),
        .RESETn (RESETn),
        .agnus  (agnus),
        .sync   (sync)
    );

    dramAddrLatch iDramAddrLatch (
        .C3       (C3),
        .RESETn   (RESETn),
        .dra      (dra),
        .ras0N    (agnus.ras0N),
        .sync     (sync),
        .rev      (rev),
        .colClear (colClear),
        .rowAddr  (rowAddr),
        .colAddr  (colAddr),
        .colValid (colValid),
        .dbEnN    (dbEnN),
        .dbDir    (dbDir)
    );

    refreshTimer iRefreshTimer (
        .C3         (C3),
        .RESETn     (RESETn),
        .interval   (interval),
        .refreshAck (refreshAck),
        .refreshReq (refreshReq)
    );

    sdramSequencer iSdramSequencer (
        .C3         (C3),
        .RESETn     (RESETn),
        .sync       (sync),
        .rowAddr    (rowAddr),
        .colAddr    (colAddr),
        .colValid   (colValid),
        .refreshReq (refreshReq),
        .colClear   (colClear),
        .refreshAck (refreshAck),
        .ready      (ready),
        .cpuCycle   (cpuCycle),
        .dmaCycle   (dmaCycle),
        .writeCycle (writeCycle),
        .sdram      (sdram)
    );

    chipRamRegs #(
        .refreshInit (refreshInit)
    ) iChipRamRegs (
        .C3         (C3),
        .RESETn     (RESETn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ready      (ready),
        .refreshAck (refreshAck),
        .rev        (rev),
        .interval   (interval)
    );

endmodule

//--- chipRamRegs.sv
// Chip RAM controller register block
// APB slave with zero wait states holding the Agnus revision, refresh
// interval, ready status and a wrapping count of refresh commands

`timescale 1ns/1ps

module chipRamRegs #(
    parameter chipRamPkg::refreshIntervalT refreshInit = 9'd290
) (
    input  logic                        C3,
    input  logic                        RESETn,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [7:0]                  paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        ready,
    input  logic                        refreshAck,
    output agnusPkg::agnusRevT          rev,
    output chipRamPkg::refreshIntervalT interval
);

    logic       access;
    logic       hit;
    logic [7:0] refreshCount;

    // Access phase and address decode
    assign access  = psel && penable;
    assign hit     = (paddr == agnusPkg::regCtrl) || (paddr == agnusPkg::regRefresh) ||
                     (paddr == agnusPkg::regStatus);
    assign pready  = 1'b1;
    assign pslverr = access && !hit;

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            rev          <= agnusPkg::rev8375;
            interval     <= refreshInit;
            refreshCount <= '0;
        end else begin
            if (access && pwrite && (paddr == agnusPkg::regCtrl)) begin
                rev <= agnusPkg::agnusRevT'(pwdata[0]);
            end
            if (access && pwrite && (paddr == agnusPkg::regRefresh)) begin
                interval <= pwdata[8:0];
            end
            // Status write clears the count
            if (access && pwrite && (paddr == agnusPkg::regStatus)) begin
                refreshCount <= '0;
            end else if (refreshAck) begin
                refreshCount <= refreshCount + 8'd1;
            end
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            agnusPkg::regCtrl:    prdata[0]    = rev;
            agnusPkg::regRefresh: prdata[8:0]  = interval;
            agnusPkg::regStatus:  prdata[15:0] = {refreshCount, 7'd0, ready};
            default:              prdata       = '0;
        endcase
    end

endmodule

//--- sdramSequencer.sv
// SDRAM command sequencer
// Runs the SDRAM power-up sequence, then serves refreshes and Agnus slots
// with activate, read or write with auto-precharge, hold and release.
// Commands reach the pins one register stage after the decision

`timescale 1ns/1ps

module sdramSequencer (
    input  logic                  C3,
    input  logic                  RESETn,
    input  agnusPkg::agnusSyncT   sync,
    input  agnusPkg::rowAddrT     rowAddr,
    input  agnusPkg::colAddrT     colAddr,
    input  logic                  colValid,
    input  logic                  refreshReq,
    output logic                  colClear,
    output logic                  refreshAck,
    output logic                  ready,
    output logic                  cpuCycle,
    output logic                  dmaCycle,
    output logic                  writeCycle,
    output chipRamPkg::sdramPinsT sdram
);

    chipRamPkg::seqStateT state;
    chipRamPkg::sdramCmdT cmd;
    logic [3:0]           seqCnt;
    // Low until the previous slot's RAS has gone away
    logic                 slotArmed;

    assign colClear = (state == chipRamPkg::stRelease);

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            state      <= chipRamPkg::stInitPre;
            cmd        <= chipRamPkg::nop;
            seqCnt     <= '0;
            slotArmed  <= 1'b0;
            refreshAck <= 1'b0;
            ready      <= 1'b0;
            cpuCycle   <= 1'b0;
            dmaCycle   <= 1'b0;
            writeCycle <= 1'b0;
            sdram      <= '{csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1,
                            clkEn: 1'b1, addr: '0};
        end else begin
            cmd        <= chipRamPkg::nop;
            refreshAck <= 1'b0;
            if (!sync.slotActive) begin
                slotArmed <= 1'b1;
            end

            //////////////////////////////////////////////////
            // Pin stage
            //////////////////////////////////////////////////

            {sdram.csN, sdram.rasN, sdram.casN, sdram.weN} <= cmd;
            case (cmd)
                chipRamPkg::precharge: sdram.addr <= 11'h400;
                chipRamPkg::modeReg:   sdram.addr <= chipRamPkg::modeWord;
                chipRamPkg::activate:  sdram.addr <= {1'b0, rowAddr};
                // Auto-precharge on bit 10
                chipRamPkg::read,
                chipRamPkg::write:     sdram.addr <= {2'b10, colAddr};
                default:               sdram.addr <= '0;
            endcase

            //////////////////////////////////////////////////
            // State machine
            //////////////////////////////////////////////////

            case (state)
                // One settling cycle, then precharge all
                chipRamPkg::stInitPre: begin
                    seqCnt <= seqCnt + 4'd1;
                    if (seqCnt == 4'd1) begin
                        cmd   <= chipRamPkg::precharge;
                        state <= chipRamPkg::stInitWait;
                    end
                end
                // Mode register, two refreshes, then ready
                chipRamPkg::stInitWait: begin
                    seqCnt <= seqCnt + 4'd1;
                    case (seqCnt)
                        4'd3:       cmd <= chipRamPkg::modeReg;
                        4'd6, 4'd9: cmd <= chipRamPkg::refresh;
                        4'd13: begin
                            ready <= 1'b1;
                            state <= chipRamPkg::stIdle;
                        end
                        default: ;
                    endcase
                end
                chipRamPkg::stIdle: begin
                    // Refresh only in bus states S3 or S0
                    if (refreshReq && sync.phaseLow) begin
                        cmd        <= chipRamPkg::refresh;
                        refreshAck <= 1'b1;
                        seqCnt     <= '0;
                        state      <= chipRamPkg::stRefWait;
                    end else if (sync.slotActive && slotArmed) begin
                        slotArmed  <= 1'b0;
                        writeCycle <= sync.write;
                        dmaCycle   <= sync.dma;
                        cpuCycle   <= !sync.dma;
                        state      <= chipRamPkg::stActivate;
                    end
                end
                // Two more cycles for tRC
                chipRamPkg::stRefWait: begin
                    seqCnt <= seqCnt + 4'd1;
                    if (seqCnt == 4'd1) begin
                        state <= chipRamPkg::stIdle;
                    end
                end
                chipRamPkg::stActivate: begin
                    cmd   <= chipRamPkg::activate;
                    state <= chipRamPkg::stColWait;
                end
                // Column arrives with falling C1
                chipRamPkg::stColWait: begin
                    if (colValid) begin
                        state <= chipRamPkg::stAccess;
                    end
                end
                chipRamPkg::stAccess: begin
                    cmd   <= writeCycle ? chipRamPkg::write : chipRamPkg::read;
                    state <= chipRamPkg::stAccessNop;
                end
                chipRamPkg::stAccessNop: begin
                    state <= chipRamPkg::stHold;
                end
                // Freeze read data on the SDRAM outputs
                chipRamPkg::stHold: begin
                    sdram.clkEn <= writeCycle;
                    state       <= chipRamPkg::stPhaseWait;
                end
                // Wait for bus state 7
                chipRamPkg::stPhaseWait: begin
                    if (sync.phaseLow) begin
                        state <= chipRamPkg::stRelease;
                    end
                end
                chipRamPkg::stRelease: begin
                    cpuCycle    <= 1'b0;
                    dmaCycle    <= 1'b0;
                    writeCycle  <= 1'b0;
                    sdram.clkEn <= 1'b1;
                    state       <= chipRamPkg::stIdle;
                end
                default: begin
                    state <= chipRamPkg::stIdle;
                end
            endcase
        end
    end

endmodule

//--- refreshTimer.sv
// SDRAM refresh timer
// Counts C3 cycles up to the programmed interval and holds a refresh
// request until the sequencer acknowledges it

`timescale 1ns/1ps

module refreshTimer (
    input  logic                        C3,
    input  logic                        RESETn,
    input  chipRamPkg::refreshIntervalT interval,
    input  logic                        refreshAck,
    output logic                        refreshReq
);

    chipRamPkg::refreshIntervalT count;

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            count      <= '0;
            refreshReq <= 1'b0;
        end else if (refreshAck) begin
            // Restart on acknowledge
            count      <= '0;
            refreshReq <= 1'b0;
        end else if (count >= interval) begin
            refreshReq <= 1'b1;
        end else begin
            count <= count + 9'd1;
        end
    end

endmodule

//--- dramAddrLatch.sv
// Agnus DRAM address latch
// Splits the multiplexed address into row and column per Agnus revision
// and drives the chip RAM data bridge enable and direction

`timescale 1ns/1ps

module dramAddrLatch (
    input  logic                C3,
    input  logic                RESETn,
    input  agnusPkg::draT       dra,
    input  logic                ras0N,
    input  agnusPkg::agnusSyncT sync,
    input  agnusPkg::agnusRevT  rev,
    input  logic                colClear,
    output agnusPkg::rowAddrT   rowAddr,
    output agnusPkg::colAddrT   colAddr,
    output logic                colValid,
    output logic                dbEnN,
    output logic                dbDir
);

    logic slotPrev;
    logic is8375;
    logic dmaA1;

    assign is8375 = (rev == agnusPkg::rev8375);
    // A1 sits one bit higher on the 8372A
    assign dmaA1  = is8375 ? dra[0] : dra[1];

    //////////////////////////////////////////////////
    // Address capture
    //////////////////////////////////////////////////

    always_ff @(posedge C3) begin
        // Row on slot start, 8372A uses RAS0n as top row bit
        if (sync.slotActive && !slotPrev) begin
            rowAddr <= is8375 ? dra : {ras0N, dra[9:1]};
        end
        // Column on falling C1
        if (sync.slotActive && sync.c1Fall) begin
            colAddr <= is8375 ? dra[9:1] : {1'b0, dra[9:2]};
        end
    end

    //////////////////////////////////////////////////
    // Control and bridge
    //////////////////////////////////////////////////

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            slotPrev <= 1'b0;
            colValid <= 1'b0;
            dbEnN    <= 1'b1;
            dbDir    <= 1'b1;
        end else begin
            slotPrev <= sync.slotActive;
            // Clear wins over a new column
            if (colClear) begin
                colValid <= 1'b0;
            end else if (sync.slotActive && sync.c1Fall) begin
                colValid <= 1'b1;
            end
            // Bridge only for DMA slots on odd words
            dbEnN <= !(sync.dma && dmaA1 && sync.slotActive);
            dbDir <= !sync.write;
        end
    end

endmodule

//--- agnusSync.sv
// Agnus strobe synchronizer
// Two flop chains for the strobes and bus phases, slot decode from the
// RAS pair and a single cycle pulse on the falling C1 phase

`timescale 1ns/1ps

module agnusSync (
    input  logic                C3,
    input  logic                RESETn,
    input  agnusPkg::agnusInT   agnus,
    output agnusPkg::agnusSyncT sync
);

    // Bit order slot, dma, write, C3 phase, C1 phase
    logic [4:0] rawIn;
    logic [4:0] meta;
    logic [4:0] stable;
    logic       c1Prev;

    // Slot is active while exactly one RAS is low
    assign rawIn = {agnus.ras1N != agnus.ras0N, !agnus.dbrN, !agnus.aweN, agnus.busPhase};

    always_ff @(posedge C3) begin
        if (!RESETn) begin
            meta   <= '0;
            stable <= '0;
            c1Prev <= 1'b0;
        end else begin
            meta   <= rawIn;
            stable <= meta;
            // Extra stage for edge detect
            c1Prev <= stable[0];
        end
    end

    assign sync.slotActive = stable[4];
    assign sync.dma        = stable[3];
    assign sync.write      = stable[2];
    assign sync.phaseLow   = (stable[1:0] == 2'b00);
    assign sync.c1Fall     = c1Prev && !stable[0];

endmodule

//--- agnusPkg.sv
// Chip RAM controller, Agnus side definitions
// Multiplexed address, revision, strobe bundles and APB register map

package agnusPkg;

    // Multiplexed DRAM address and its split halves
    typedef logic [9:0] draT;
    typedef logic [9:0] rowAddrT;
    typedef logic [8:0] colAddrT;

    typedef enum logic {
        rev8372a = 1'b0,
        rev8375  = 1'b1
    } agnusRevT;

    // Raw Agnus strobes, busPhase[0] is C1 and busPhase[1] is C3
    typedef struct packed {
        logic       dbrN;
        logic       aweN;
        logic       ras1N;
        logic       ras0N;
        logic [1:0] busPhase;
    } agnusInT;

    // Synchronized and decoded strobes
    typedef struct packed {
        logic slotActive;
        logic dma;
        logic write;
        logic phaseLow;
        logic c1Fall;
    } agnusSyncT;

    // APB word addresses
    localparam logic [7:0] regCtrl    = 8'h00;
    localparam logic [7:0] regRefresh = 8'h04;
    localparam logic [7:0] regStatus  = 8'h08;

endpackage

//--- chipRamPkg.sv
// Chip RAM controller, SDRAM side definitions
// Command encodings, output pin bundle, sequencer states and refresh width

package chipRamPkg;

    //////////////////////////////////////////////////
    // SDRAM commands and pins
    //////////////////////////////////////////////////

    // Bit order CSn, RASn, CASn, WEn
    typedef enum logic [3:0] {
        nop       = 4'b1111,
        precharge = 4'b0010,
        activate  = 4'b0011,
        read      = 4'b0101,
        write     = 4'b0100,
        refresh   = 4'b0001,
        modeReg   = 4'b0000
    } sdramCmdT;

    typedef logic [10:0] sdramAddrT;

    // Output bundle, 16 bits
    typedef struct packed {
        logic      csN;
        logic      rasN;
        logic      casN;
        logic      weN;
        logic      clkEn;
        sdramAddrT addr;
    } sdramPinsT;

    // CAS latency 2, sequential, one word bursts
    localparam sdramAddrT modeWord = 11'b000_0010_0000;

    // Refresh interval in C3 cycles
    typedef logic [8:0] refreshIntervalT;

    //////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        stInitPre, stInitWait, stIdle, stRefWait, stActivate, stColWait,
        stAccess, stAccessNop, stHold, stPhaseWait, stRelease
    } seqStateT;

endpackage
